/* build.f */
addmul_pkg.sv
addmul_lane.sv
addmul_core.sv
addmul_slave.sv
addmul_top.sv
tb_addmul.sv

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator, result taken from the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f build.f --top-module tb_addmul -o sim_addmul

./obj_dir/sim_addmul > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation FAILED" sim.log; then
  exit 1
fi

if ! grep -q "Simulation PASSED" sim.log; then
  echo "No result found in sim.log"
  exit 1
fi

exit 0

/* tb_addmul.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_addmul import addmul_pkg::*; ();

  localparam int N_LANES    = 4;
  localparam int WORD_BITS  = N_LANES * LANE_BITS;
  localparam int CLK_PERIOD = 100;
  localparam int NUM_RANDOM = 200;
  localparam int MAX_GAP    = 3;
  localparam int NUM_AXI    = 20;
  localparam int HOLD_CYCLES = 5;
  localparam logic [31:0] SEED = 32'h1dda_2662;

  // Each beat takes at most MAX_GAP+1 cycles, each bus access about 10
  localparam int TIMEOUT_CYCLES =
    2 * ((NUM_RANDOM + 4) * (MAX_GAP + 1) + NUM_AXI * 10 + 2 * HOLD_CYCLES) + 100;

  logic                      aclk;
  logic                      aresetn;
  logic [AXIL_ADDR_BITS-1:0] awaddr;
  logic                      awvalid;
  logic                      awready;
  logic [AXIL_DATA_BITS-1:0] wdata;
  logic [AXIL_STRB_BITS-1:0] wstrb;
  logic                      wvalid;
  logic                      wready;
  logic [AXIL_RESP_BITS-1:0] bresp;
  logic                      bvalid;
  logic                      bready;
  logic [AXIL_ADDR_BITS-1:0] araddr;
  logic                      arvalid;
  logic                      arready;
  logic [AXIL_DATA_BITS-1:0] rdata;
  logic [AXIL_RESP_BITS-1:0] rresp;
  logic                      rvalid;
  logic                      rready;
  logic                      in_valid;
  logic                      in_last;
  logic [WORD_BITS-1:0]      in_data;
  logic                      out_valid;
  logic                      out_last;
  logic [WORD_BITS-1:0]      out_data;

  // Host-side copy of registers 0 and 1
  logic [AXIL_DATA_BITS-1:0] model_reg [2];

  // Expected output words in order
  logic [WORD_BITS-1:0] exp_data_q [$];
  logic                 exp_last_q [$];
  int                   exp_cycle_q [$];

  int cycle = 0;
  int words_sent;

  addmul_top #(
    .N_LANES (N_LANES)
  ) dut0 (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .awaddr    (awaddr),
    .awvalid   (awvalid),
    .awready   (awready),
    .wdata     (wdata),
    .wstrb     (wstrb),
    .wvalid    (wvalid),
    .wready    (wready),
    .bresp     (bresp),
    .bvalid    (bvalid),
    .bready    (bready),
    .araddr    (araddr),
    .arvalid   (arvalid),
    .arready   (arready),
    .rdata     (rdata),
    .rresp     (rresp),
    .rvalid    (rvalid),
    .rready    (rready),
    .in_valid  (in_valid),
    .in_last   (in_last),
    .in_data   (in_data),
    .out_valid (out_valid),
    .out_last  (out_last),
    .out_data  (out_data)
  );

  initial
  begin
    aclk = 1'b0;
    forever #(CLK_PERIOD / 2) aclk = ~aclk;
  end

  always @(posedge aclk)
    cycle <= cycle + 1;

  // ------------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------------
  task automatic stop_with_failure();
    $display("Simulation FAILED");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [WORD_BITS-1:0] actual,
                             input logic [WORD_BITS-1:0] expected);
    if (actual !== expected)
    begin
      $display("Fail at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
      stop_with_failure();
    end
  endtask

  task automatic next_cycle();
    @(posedge aclk);
    #1;
  endtask

  // Multiply, then add, keep the low lane bits
  function automatic logic [LANE_BITS-1:0] addmul_ref(input logic [LANE_BITS-1:0] data,
                                                      input logic [FACTOR_BITS-1:0] mul,
                                                      input logic [FACTOR_BITS-1:0] add);
    logic [2*LANE_BITS-1:0] full;
    full = (2*LANE_BITS)'(data) * (2*LANE_BITS)'(mul) + (2*LANE_BITS)'(add);
    return full[LANE_BITS-1:0];
  endfunction

  function automatic logic [AXIL_ADDR_BITS-1:0] reg_addr(input logic [REG_IDX_BITS-1:0] idx);
    return {idx, {REG_IDX_LSB{1'b0}}};
  endfunction

  function automatic logic [WORD_BITS-1:0] random_word();
    logic [WORD_BITS-1:0] w;
    for (int k = 0; k < N_LANES; k++)
      w[k*LANE_BITS +: LANE_BITS] = $urandom;
    return w;
  endfunction

  // ------------------------------------------------------------------
  // AXI4-Lite host
  // ------------------------------------------------------------------
  task automatic axil_write(input logic [AXIL_ADDR_BITS-1:0] addr,
                            input logic [AXIL_DATA_BITS-1:0] data,
                            input logic [AXIL_STRB_BITS-1:0] strb, input int hold);
    int idx;
    awaddr  = addr;
    wdata   = data;
    wstrb   = strb;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    // Ready seen here is sampled with valid at the next edge
    do
      next_cycle();
    while (!awready);
    check_value("wready", wready, 1'b1);
    next_cycle();
    awvalid = 1'b0;
    wvalid  = 1'b0;
    idx = int'(addr[REG_IDX_LSB +: REG_IDX_BITS]);
    if (idx < 2)
    begin
      for (int i = 0; i < AXIL_STRB_BITS; i++)
      begin
        if (strb[i])
          model_reg[idx][i*8 +: 8] = data[i*8 +: 8];
      end
    end
    while (!bvalid)
      next_cycle();
    repeat (hold)
    begin
      next_cycle();
      check_value("bvalid", bvalid, 1'b1);
    end
    check_value("bresp", bresp, AXIL_RESP_OKAY);
    bready = 1'b1;
    next_cycle();
    bready = 1'b0;
  endtask

  task automatic axil_read(input logic [AXIL_ADDR_BITS-1:0] addr,
                           output logic [AXIL_DATA_BITS-1:0] data, input int hold);
    logic [AXIL_DATA_BITS-1:0] first;
    araddr  = addr;
    arvalid = 1'b1;
    do
      next_cycle();
    while (!arready);
    next_cycle();
    arvalid = 1'b0;
    while (!rvalid)
      next_cycle();
    first = rdata;
    repeat (hold)
    begin
      next_cycle();
      check_value("rvalid", rvalid, 1'b1);
      check_value("rdata", rdata, first);
    end
    check_value("rresp", rresp, AXIL_RESP_OKAY);
    data   = rdata;
    rready = 1'b1;
    next_cycle();
    rready = 1'b0;
  endtask

  task automatic expect_read(input logic [AXIL_ADDR_BITS-1:0] addr,
                             input logic [AXIL_DATA_BITS-1:0] expected, input string name);
    logic [AXIL_DATA_BITS-1:0] got;
    axil_read(addr, got, 0);
    check_value(name, got, expected);
  endtask

  // ------------------------------------------------------------------
  // Stream stimulus
  // ------------------------------------------------------------------
  task automatic send_word(input logic [WORD_BITS-1:0] data, input logic last);
    logic [WORD_BITS-1:0] exp_word;
    for (int k = 0; k < N_LANES; k++)
      exp_word[k*LANE_BITS +: LANE_BITS] = addmul_ref(data[k*LANE_BITS +: LANE_BITS],
        model_reg[0][FACTOR_BITS-1:0], model_reg[1][FACTOR_BITS-1:0]);
    in_data  = data;
    in_last  = last;
    in_valid = 1'b1;
    exp_data_q.push_back(exp_word);
    exp_last_q.push_back(last);
    exp_cycle_q.push_back(cycle + 2);
    words_sent++;
    next_cycle();
    in_valid = 1'b0;
    in_last  = 1'b0;
  endtask

  // Two cycles of latency, then word_count catches up
  task automatic wait_for_drain();
    repeat (4)
      next_cycle();
  endtask

  // ------------------------------------------------------------------
  // Output checker
  // ------------------------------------------------------------------
  initial
  begin : compare_outputs
    logic [WORD_BITS-1:0] exp_word;
    logic                 exp_last;
    int                   exp_cycle;
    forever
    begin
      next_cycle();
      if (out_valid)
      begin
        if (exp_data_q.size() == 0)
        begin
          $display("Output word at %0t ns with no input word outstanding", $time);
          stop_with_failure();
        end
        else
        begin
          exp_word  = exp_data_q.pop_front();
          exp_last  = exp_last_q.pop_front();
          exp_cycle = exp_cycle_q.pop_front();
          check_value("out_data", out_data, exp_word);
          check_value("out_last", out_last, exp_last);
          check_value("out_valid cycle", cycle, exp_cycle);
        end
      end
    end
  end

  initial
  begin : watchdog
    repeat (TIMEOUT_CYCLES) @(posedge aclk);
    $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
    stop_with_failure();
  end

  // ------------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------------
  initial
  begin : run_tests
    logic [AXIL_DATA_BITS-1:0] rd_val;
    int gap;
    void'($urandom(SEED));
    aresetn  = 1'b0;
    awaddr   = '0;
    awvalid  = 1'b0;
    wdata    = '0;
    wstrb    = '0;
    wvalid   = 1'b0;
    bready   = 1'b0;
    araddr   = '0;
    arvalid  = 1'b0;
    rready   = 1'b0;
    in_valid = 1'b0;
    in_last  = 1'b0;
    in_data  = '0;
    model_reg[0] = '0;
    model_reg[1] = '0;
    words_sent   = 0;
    repeat (4) @(posedge aclk);
    #1;
    aresetn = 1'b1;

    // Handshake and stream outputs idle out of reset
    check_value("awready", awready, 1'b0);
    check_value("wready", wready, 1'b0);
    check_value("arready", arready, 1'b0);
    check_value("bvalid", bvalid, 1'b0);
    check_value("rvalid", rvalid, 1'b0);
    check_value("out_valid", out_valid, 1'b0);

    // Reset values, and zero output with zero factors
    expect_read(reg_addr(MUL_FACT_REG), '0, "mul register after reset");
    expect_read(reg_addr(ADD_FACT_REG), '0, "add register after reset");
    expect_read(reg_addr(WORD_CNT_REG), '0, "word count after reset");
    send_word(random_word(), 1'b1);
    wait_for_drain();

    // Register access
    axil_write(reg_addr(MUL_FACT_REG), 32'h1234_abcd, 4'hf, 0);
    expect_read(reg_addr(MUL_FACT_REG), 32'h1234_abcd, "mul register");
    axil_write(reg_addr(ADD_FACT_REG), 32'h5a5a_0f0f, 4'hf, 0);
    expect_read(reg_addr(ADD_FACT_REG), 32'h5a5a_0f0f, "add register");
    axil_write(reg_addr(MUL_FACT_REG), 32'hffff_77ff, 4'b0010, 0);
    expect_read(reg_addr(MUL_FACT_REG), 32'h1234_77cd, "mul register after byte 1 write");
    expect_read(reg_addr(2'd3), '0, "unused register");
    axil_write(reg_addr(WORD_CNT_REG), 32'hdead_beef, 4'hf, 0);
    expect_read(reg_addr(WORD_CNT_REG), words_sent, "word count after write");

    // Random stream with random gaps
    axil_write(reg_addr(MUL_FACT_REG), $urandom, 4'hf, 0);
    axil_write(reg_addr(ADD_FACT_REG), $urandom, 4'hf, 0);
    repeat (NUM_RANDOM)
    begin
      send_word(random_word(), 1'($urandom_range(0, 1)));
      gap = int'($urandom_range(0, MAX_GAP));
      repeat (gap)
        next_cycle();
    end
    wait_for_drain();

    // Largest factors and data
    axil_write(reg_addr(MUL_FACT_REG), 32'h0000_ffff, 4'hf, 0);
    axil_write(reg_addr(ADD_FACT_REG), 32'h0000_ffff, 4'hf, 0);
    send_word({N_LANES{32'hffff_ffff}}, 1'b1);
    wait_for_drain();

    expect_read(reg_addr(WORD_CNT_REG), words_sent, "word count after stream");

    // Host stalls on the response channels
    axil_write(reg_addr(ADD_FACT_REG), 32'h0000_0101, 4'hf, HOLD_CYCLES);
    axil_read(reg_addr(ADD_FACT_REG), rd_val, HOLD_CYCLES);
    check_value("add register after stall", rd_val, model_reg[1]);

    if (exp_data_q.size() != 0)
    begin
      $display("%0d expected output words never appeared", exp_data_q.size());
      stop_with_failure();
    end
    else
    begin
      $display("Simulation PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* addmul_top.sv */
`timescale 1ns/1ps
`default_nettype none

module addmul_top import addmul_pkg::*; #(
  parameter int N_LANES = 4
) (
  input  logic                         aclk,
  input  logic                         aresetn,

  // AXI4-Lite control
  input  logic [AXIL_ADDR_BITS-1:0]    awaddr,
  input  logic                         awvalid,
  output logic                         awready,
  input  logic [AXIL_DATA_BITS-1:0]    wdata,
  input  logic [AXIL_STRB_BITS-1:0]    wstrb,
  input  logic                         wvalid,
  output logic                         wready,
  output logic [AXIL_RESP_BITS-1:0]    bresp,
  output logic                         bvalid,
  input  logic                         bready,
  input  logic [AXIL_ADDR_BITS-1:0]    araddr,
  input  logic                         arvalid,
  output logic                         arready,
  output logic [AXIL_DATA_BITS-1:0]    rdata,
  output logic [AXIL_RESP_BITS-1:0]    rresp,
  output logic                         rvalid,
  input  logic                         rready,

  // Stream in
  input  logic                         in_valid,
  input  logic                         in_last,
  input  logic [N_LANES*LANE_BITS-1:0] in_data,

  // Stream out
  output logic                         out_valid,
  output logic                         out_last,
  output logic [N_LANES*LANE_BITS-1:0] out_data
);

  logic [FACTOR_BITS-1:0] mul_factor;
  logic [FACTOR_BITS-1:0] add_factor;
  logic [COUNT_BITS-1:0]  word_count;

  // ------------------------------------------------------------------
  // Register slave
  // ------------------------------------------------------------------
  addmul_slave u_slave (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .awaddr     (awaddr),
    .awvalid    (awvalid),
    .awready    (awready),
    .wdata      (wdata),
    .wstrb      (wstrb),
    .wvalid     (wvalid),
    .wready     (wready),
    .bresp      (bresp),
    .bvalid     (bvalid),
    .bready     (bready),
    .araddr     (araddr),
    .arvalid    (arvalid),
    .arready    (arready),
    .rdata      (rdata),
    .rresp      (rresp),
    .rvalid     (rvalid),
    .rready     (rready),
    .word_count (word_count),
    .mul_factor (mul_factor),
    .add_factor (add_factor)
  );

  // ------------------------------------------------------------------
  // Multiply-add core
  // ------------------------------------------------------------------
  addmul_core #(
    .N_LANES (N_LANES)
  ) u_core (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .in_valid   (in_valid),
    .in_last    (in_last),
    .in_data    (in_data),
    .mul_factor (mul_factor),
    .add_factor (add_factor),
    .out_valid  (out_valid),
    .out_last   (out_last),
    .out_data   (out_data),
    .word_count (word_count)
  );

endmodule

`default_nettype wire

/* addmul_slave.sv */
`timescale 1ns/1ps
`default_nettype none

module addmul_slave import addmul_pkg::*; (
  input  logic                      aclk,
  input  logic                      aresetn,

  input  logic [AXIL_ADDR_BITS-1:0] awaddr,
  input  logic                      awvalid,
  output logic                      awready,
  input  logic [AXIL_DATA_BITS-1:0] wdata,
  input  logic [AXIL_STRB_BITS-1:0] wstrb,
  input  logic                      wvalid,
  output logic                      wready,
  output logic [AXIL_RESP_BITS-1:0] bresp,
  output logic                      bvalid,
  input  logic                      bready,
  input  logic [AXIL_ADDR_BITS-1:0] araddr,
  input  logic                      arvalid,
  output logic                      arready,
  output logic [AXIL_DATA_BITS-1:0] rdata,
  output logic [AXIL_RESP_BITS-1:0] rresp,
  output logic                      rvalid,
  input  logic                      rready,

  input  logic [COUNT_BITS-1:0]     word_count,
  output logic [FACTOR_BITS-1:0]    mul_factor,
  output logic [FACTOR_BITS-1:0]    add_factor
);

  // Latched addresses and write gating
  logic [AXIL_ADDR_BITS-1:0] awaddr_q;
  logic [AXIL_ADDR_BITS-1:0] araddr_q;
  logic                      aw_en;
  logic                      reg_wren;
  logic                      reg_rden;
  logic [REG_IDX_BITS-1:0]   wr_idx;
  logic [REG_IDX_BITS-1:0]   rd_idx;
  logic [AXIL_DATA_BITS-1:0] rd_word;

  // Factor registers, indices 0 and 1 only
  logic [1:0][AXIL_DATA_BITS-1:0] slv_reg;

  assign wr_idx = awaddr_q[REG_IDX_LSB +: REG_IDX_BITS];
  assign rd_idx = araddr_q[REG_IDX_LSB +: REG_IDX_BITS];

  // ------------------------------------------------------------------
  // Write channel
  // ------------------------------------------------------------------
  assign reg_wren = awready && awvalid && wready && wvalid;

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      awready  <= 1'b0;
      wready   <= 1'b0;
      aw_en    <= 1'b1;
      awaddr_q <= '0;
    end
    else if (!awready && awvalid && wvalid && aw_en)
    begin
      // Both ready lines pulse together for one cycle
      awready  <= 1'b1;
      wready   <= 1'b1;
      aw_en    <= 1'b0;
      awaddr_q <= awaddr;
    end
    else
    begin
      awready <= 1'b0;
      wready  <= 1'b0;
      if (bready && bvalid)
        aw_en <= 1'b1;
    end
  end

  // Byte-wise update, writes to 2 and 3 dropped
  always_ff @(posedge aclk)
  begin
    if (!aresetn)
      slv_reg <= '0;
    else if (reg_wren && (wr_idx == MUL_FACT_REG || wr_idx == ADD_FACT_REG))
    begin
      for (int i = 0; i < AXIL_STRB_BITS; i++)
      begin
        if (wstrb[i])
          slv_reg[wr_idx[0]][i*8 +: 8] <= wdata[i*8 +: 8];
      end
    end
  end

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
      bvalid <= 1'b0;
    else if (reg_wren && !bvalid)
      bvalid <= 1'b1;
    else if (bready && bvalid)
      bvalid <= 1'b0;
  end

  assign bresp = AXIL_RESP_OKAY;

  // ------------------------------------------------------------------
  // Read channel
  // ------------------------------------------------------------------
  assign reg_rden = arready && arvalid && !rvalid;

  // One read in flight, so no new arready while rvalid is up
  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      arready  <= 1'b0;
      araddr_q <= '0;
    end
    else if (!arready && arvalid && !rvalid)
    begin
      arready  <= 1'b1;
      araddr_q <= araddr;
    end
    else
      arready <= 1'b0;
  end

  always_comb
  begin
    case (rd_idx)
      MUL_FACT_REG: rd_word = slv_reg[0];
      ADD_FACT_REG: rd_word = slv_reg[1];
      WORD_CNT_REG: rd_word = word_count;
      default:      rd_word = '0;
    endcase
  end

  // Read data held until rready
  always_ff @(posedge aclk)
  begin
    if (reg_rden)
      rdata <= rd_word;
  end

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
      rvalid <= 1'b0;
    else if (reg_rden)
      rvalid <= 1'b1;
    else if (rvalid && rready)
      rvalid <= 1'b0;
  end

  assign rresp = AXIL_RESP_OKAY;

  // Factors are the low halves
  assign mul_factor = slv_reg[0][FACTOR_BITS-1:0];
  assign add_factor = slv_reg[1][FACTOR_BITS-1:0];

  // ------------------------------------------------------------------
  // Protocol checks
  // ------------------------------------------------------------------
  a_bvalid_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    bvalid && !bready |=> bvalid);

  a_rvalid_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    rvalid && !rready |=> rvalid && $stable(rdata));

  // No new write accepted before the response is taken
  a_no_aw_during_b: assert property (@(posedge aclk) disable iff (!aresetn)
    bvalid |-> !awready);

endmodule

`default_nettype wire

/* addmul_core.sv */
`timescale 1ns/1ps
`default_nettype none

module addmul_core import addmul_pkg::*; #(
  parameter int N_LANES = 4
) (
  input  logic                         aclk,
  input  logic                         aresetn,

  input  logic                         in_valid,
  input  logic                         in_last,
  input  logic [N_LANES*LANE_BITS-1:0] in_data,

  input  logic [FACTOR_BITS-1:0]       mul_factor,
  input  logic [FACTOR_BITS-1:0]       add_factor,

  output logic                         out_valid,
  output logic                         out_last,
  output logic [N_LANES*LANE_BITS-1:0] out_data,
  output logic [COUNT_BITS-1:0]        word_count
);

  // Stage 1 copies of the sideband
  logic valid_s1;
  logic last_s1;

  // ------------------------------------------------------------------
  // Lane array
  // ------------------------------------------------------------------
  for (genvar k = 0; k < N_LANES; k++)
  begin : g_lane
    addmul_lane u_lane (
      .aclk       (aclk),
      .data       (in_data[k*LANE_BITS +: LANE_BITS]),
      .mul_factor (mul_factor),
      .add_factor (add_factor),
      .result     (out_data[k*LANE_BITS +: LANE_BITS])
    );
  end

  // ------------------------------------------------------------------
  // Valid and last, two stages to match the lanes
  // ------------------------------------------------------------------
  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      valid_s1  <= 1'b0;
      last_s1   <= 1'b0;
      out_valid <= 1'b0;
      out_last  <= 1'b0;
    end
    else
    begin
      valid_s1  <= in_valid;
      last_s1   <= in_last & in_valid;
      out_valid <= valid_s1;
      out_last  <= last_s1;
    end
  end

  // Output word counter, wraps at 2^32
  always_ff @(posedge aclk)
  begin
    if (!aresetn)
      word_count <= '0;
    else if (out_valid)
      word_count <= word_count + 1'b1;
  end

  // ------------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------------
  // Latency through the whole core is fixed at two
  a_latency: assert property (@(posedge aclk) disable iff (!aresetn)
    out_valid == $past(in_valid, 2));

endmodule

`default_nettype wire

/* addmul_lane.sv */
`timescale 1ns/1ps
`default_nettype none

module addmul_lane import addmul_pkg::*; (
  input  logic                   aclk,
  input  logic [LANE_BITS-1:0]   data,
  input  logic [FACTOR_BITS-1:0] mul_factor,
  input  logic [FACTOR_BITS-1:0] add_factor,
  output logic [LANE_BITS-1:0]   result
);

  localparam int PAD_BITS = LANE_BITS - FACTOR_BITS;

  // Factors widened to lane width
  logic [LANE_BITS-1:0] mul_ext;
  logic [LANE_BITS-1:0] add_ext;

  // Stage 1 product, already truncated
  logic [LANE_BITS-1:0] prod_q;

  assign mul_ext = {{PAD_BITS{1'b0}}, mul_factor};
  assign add_ext = {{PAD_BITS{1'b0}}, add_factor};

  // ------------------------------------------------------------------
  // Stage 1: multiply
  // ------------------------------------------------------------------
  // Only the low LANE_BITS of the product are kept,
  // the upper bits never reach the result
  always_ff @(posedge aclk)
  begin
    prod_q <= data * mul_ext;
  end

  // ------------------------------------------------------------------
  // Stage 2: add
  // ------------------------------------------------------------------
  // Carry out of bit 31 wraps away
  always_ff @(posedge aclk)
  begin
    result <= prod_q + add_ext;
  end

endmodule

`default_nettype wire

/* addmul_pkg.sv */
`default_nettype none

package addmul_pkg;

  // ------------------------------------------------------------------
  // AXI4-Lite bus geometry
  // ------------------------------------------------------------------
  localparam int AXIL_DATA_BITS = 32;
  localparam int AXIL_ADDR_BITS = 4;
  localparam int AXIL_STRB_BITS = AXIL_DATA_BITS / 8;
  localparam int AXIL_RESP_BITS = 2;

  localparam logic [AXIL_RESP_BITS-1:0] AXIL_RESP_OKAY = 2'b00;

  // Register index sits above the byte offset
  localparam int REG_IDX_LSB  = $clog2(AXIL_STRB_BITS);
  localparam int REG_IDX_BITS = AXIL_ADDR_BITS - REG_IDX_LSB;

  // ------------------------------------------------------------------
  // Stream and factor widths
  // ------------------------------------------------------------------
  localparam int LANE_BITS   = 32;
  localparam int FACTOR_BITS = 16;
  localparam int COUNT_BITS  = 32;

  // Register map
  localparam logic [REG_IDX_BITS-1:0] MUL_FACT_REG = 2'd0;
  localparam logic [REG_IDX_BITS-1:0] ADD_FACT_REG = 2'd1;
  localparam logic [REG_IDX_BITS-1:0] WORD_CNT_REG = 2'd2;

endpackage

`default_nettype wire
